// ==== Bender.yml ====
package:
  name: port_parser

sources:
  - rtl/net_field_pkg.sv
  - rtl/stream_pkg.sv
  - rtl/port_field_locate.sv
  - rtl/src_port_acl.sv
  - rtl/dest_port_filter.sv
  - rtl/verdict_merge.sv
  - rtl/port_parser_top.sv
  - target: test
    files:
      - bench/port_parser_sva.sv
      - bench/port_parser_checker.sv
      - bench/tb_port_parser.sv

// ==== bench/port_parser_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_parser_checker
    import stream_pkg::*;
(
    input  logic       aclk,
    input  logic       reset,
    input  axis_beat_t out_beat,
    input  logic       out_ready,
    input  side_out_t  side_out,
    input  side_out_t  exp_side,
    output int         pass_cnt,
    output int         fail_cnt
);

    int frame_no;

    // Verdict is final on the accepted last beat of each frame
    always @(posedge aclk) begin : compare
        logic bad;
        if (reset) begin
            frame_no = 0;
            pass_cnt = 0;
            fail_cnt = 0;
        end else if (out_beat.valid && out_beat.last && out_ready) begin
            bad = 1'b0;
            if (side_out.route_mask !== exp_side.route_mask) begin
                $display("** Error at %0t ns: frame %0d route_mask is %h, expected %h",
                    $time, frame_no, side_out.route_mask, exp_side.route_mask);
                bad = 1'b1;
            end
            if (side_out.poisoned !== exp_side.poisoned) begin
                $display("** Error at %0t ns: frame %0d poisoned is %b, expected %b",
                    $time, frame_no, side_out.poisoned, exp_side.poisoned);
                bad = 1'b1;
            end
            if (side_out.parsing_done !== exp_side.parsing_done) begin
                $display("** Error at %0t ns: frame %0d parsing_done is %b, expected %b",
                    $time, frame_no, side_out.parsing_done, exp_side.parsing_done);
                bad = 1'b1;
            end
            if (bad) begin
                fail_cnt++;
                $display("Frame %0d mismatch", frame_no);
            end else begin
                pass_cnt++;
                $display("Frame %0d ok, route %h poisoned %b done %b", frame_no,
                    side_out.route_mask, side_out.poisoned, side_out.parsing_done);
            end
            frame_no++;
        end
    end

endmodule

`default_nettype wire

// ==== bench/port_parser_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_parser_sva
    import stream_pkg::*;
(
    input logic       aclk,
    input logic       reset,
    input axis_beat_t in_beat,
    input logic       in_ready,
    input axis_beat_t out_beat,
    input logic       out_ready,
    input side_in_t   side_in,
    input side_out_t  side_out
);

    logic accept;
    int   assert_fail_cnt = 0;

    assign accept = in_beat.valid & out_ready;

    a_passthrough: assert property (@(posedge aclk) disable iff (reset) out_beat == in_beat)
        else begin
            $error("out_beat differs from in_beat");
            assert_fail_cnt++;
        end

    a_ready: assert property (@(posedge aclk) disable iff (reset) in_ready == out_ready)
        else begin
            $error("in_ready does not follow out_ready");
            assert_fail_cnt++;
        end

    // No destination port seen yet in a fresh frame
    a_clear: assert property (@(posedge aclk) disable iff (reset)
        ($past(reset) || $past(accept && in_beat.last)) && !accept && side_in.has_ports
        |-> !side_out.parsing_done)
        else begin
            $error("parsing_done set before any destination port");
            assert_fail_cnt++;
        end

    // Sideband only moves with accepted beats
    a_hold: assert property (@(posedge aclk) disable iff (reset)
        (!accept && !$past(reset)) ##1 !accept |-> $stable(side_out))
        else begin
            $error("side_out changed while the stream was stalled");
            assert_fail_cnt++;
        end

endmodule

bind port_parser_top port_parser_sva i_port_parser_sva (.*);

`default_nettype wire

// ==== bench/tb_port_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_port_parser
    import net_field_pkg::*;
    import stream_pkg::*;
();

    localparam int NUM_ROWS = 10;
    localparam int FRAME_BEATS = 8;
    localparam int FRAME_BYTES = FRAME_BEATS * BUS_BYTES;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * FRAME_BEATS * 4 + 20;

    // One frame of stimulus
    // Table entry k holds tbl_base + k
    typedef struct packed {
        port_t                   sport;
        port_t                   dport;
        logic [OFFSET_WIDTH-1:0] offset;
        port_t                   tbl_base;
        route_mask_t             must;
        side_in_t                side;
        filter_cfg_t             cfg;
        side_out_t               exp;
    } row_t;

    logic                    aclk;
    logic                    reset;
    axis_beat_t              in_beat;
    logic                    in_ready;
    axis_beat_t              out_beat;
    logic                    out_ready;
    logic [OFFSET_WIDTH-1:0] added_offset;
    filter_cfg_t             cfg;
    port_t                   table_ports [NUM_ROUTES];
    route_mask_t             must_match;
    side_in_t                side_in;
    side_out_t               side_out;
    side_out_t               exp_side;
    int                      pass_cnt;
    int                      fail_cnt;
    int                      assert_fails;
    int                      cycle_cnt;
    integer                  seed;
    row_t                    rows [NUM_ROWS];

    port_parser_top i_port_parser_top (.*);

    port_parser_checker i_port_parser_checker (.*);

    always #5 aclk = ~aclk;

    // Random back-pressure with ready about three cycles in four
    always @(posedge aclk) begin
        out_ready <= ($random(seed) & 3) != 0;
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles with frames still pending", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // Expected verdicts worked out by hand from the filter rules
    task automatic load_rows();
        rows[0] = '{16'h0050, 16'h1003, 7'd0, 16'h1000, 16'h000F, '{16'hFFFF, 1'b0, 1'b0, 1'b1},
            '{16'h0051, 1'b1, 16'h1003, 1'b1}, '{16'hFFF8, 1'b1, 1'b1}};
        rows[1] = '{16'h0050, 16'h1003, 7'd0, 16'h1000, 16'h000F, '{16'hFFFF, 1'b0, 1'b0, 1'b1},
            '{16'h0051, 1'b0, 16'h1003, 1'b1}, '{16'hFFF8, 1'b0, 1'b1}};
        rows[2] = '{16'h0050, 16'h1005, 7'd0, 16'h1000, 16'h00F0, '{16'hFFFF, 1'b0, 1'b0, 1'b1},
            '{16'h0050, 1'b1, 16'h1003, 1'b1}, '{16'hFF2F, 1'b1, 1'b1}};
        rows[3] = '{16'h0035, 16'h100A, 7'd0, 16'h1000, 16'hFF00, '{16'h0F0F, 1'b0, 1'b0, 1'b1},
            '{16'h0035, 1'b1, 16'h100A, 1'b1}, '{16'h040F, 1'b0, 1'b1}};
        // No transport header so the ports are ignored
        rows[4] = '{16'h1111, 16'h2222, 7'd0, 16'h1000, 16'h0000, '{16'hA5A5, 1'b1, 1'b0, 1'b0},
            '{16'h0050, 1'b1, 16'h1003, 1'b1}, '{16'hA5A5, 1'b1, 1'b0}};
        rows[5] = '{16'h0050, 16'h1003, 7'd0, 16'h1000, 16'h00FF, '{16'hFFFF, 1'b0, 1'b1, 1'b0},
            '{16'h0051, 1'b1, 16'h1004, 1'b1}, '{16'hFF00, 1'b0, 1'b1}};
        // IP options push the ports into later beats
        rows[6] = '{16'h1234, 16'h100C, 7'd4, 16'h1000, 16'hF000, '{16'hFFFF, 1'b0, 1'b0, 1'b1},
            '{16'h1234, 1'b1, 16'h1001, 1'b1}, '{16'h1FFF, 1'b1, 1'b1}};
        rows[7] = '{16'h1234, 16'h1001, 7'd8, 16'h1000, 16'h0003, '{16'hFFFF, 1'b0, 1'b0, 1'b1},
            '{16'h1234, 1'b1, 16'h1001, 1'b1}, '{16'hFFFE, 1'b0, 1'b1}};
        rows[8] = '{16'h00A0, 16'h100F, 7'd2, 16'h1000, 16'h8000, '{16'h8001, 1'b1, 1'b0, 1'b1},
            '{16'h00A0, 1'b1, 16'h100F, 1'b1}, '{16'h8001, 1'b1, 1'b1}};
        rows[9] = '{16'h0101, 16'h2000, 7'd0, 16'h3000, 16'hFFFF, '{16'hFFFF, 1'b0, 1'b0, 1'b1},
            '{16'h0202, 1'b0, 16'h0303, 1'b0}, '{16'h0000, 1'b0, 1'b1}};
    endtask

    task automatic send_frame(input int r);
        logic [7:0] bytes [FRAME_BYTES];
        axis_beat_t beat;
        int         spos;
        int         dpos;
        spos = SPORT_OFFSET + int'(rows[r].offset);
        dpos = DPORT_OFFSET + int'(rows[r].offset);
        for (int i = 0; i < FRAME_BYTES; i++) begin
            bytes[i] = 8'(i * 13 + r * 29 + 1);
        end
        // Low byte of each port goes in the lower byte lane
        bytes[spos]     = rows[r].sport[7:0];
        bytes[spos + 1] = rows[r].sport[15:8];
        bytes[dpos]     = rows[r].dport[7:0];
        bytes[dpos + 1] = rows[r].dport[15:8];
        added_offset <= rows[r].offset;
        cfg          <= rows[r].cfg;
        must_match   <= rows[r].must;
        side_in      <= rows[r].side;
        exp_side     <= rows[r].exp;
        for (int k = 0; k < NUM_ROUTES; k++) begin
            table_ports[k] <= rows[r].tbl_base + port_t'(k);
        end
        for (int n = 0; n < FRAME_BEATS; n++) begin
            beat.valid = 1'b1;
            beat.last  = (n == FRAME_BEATS - 1);
            beat.keep  = '1;
            for (int i = 0; i < BUS_BYTES; i++) begin
                beat.data[8*i +: 8] = bytes[n * BUS_BYTES + i];
            end
            in_beat <= beat;
            // Hold the beat until the edge that accepts it
            @(posedge aclk);
            while (!in_ready) begin
                @(posedge aclk);
            end
        end
    endtask

    initial begin
        aclk         = 1'b0;
        reset        = 1'b1;
        seed         = 63;
        cycle_cnt    = 0;
        in_beat      = '0;
        out_ready    = 1'b0;
        added_offset = '0;
        cfg          = '0;
        must_match   = '0;
        side_in      = '0;
        exp_side     = '0;
        for (int k = 0; k < NUM_ROUTES; k++) begin
            table_ports[k] = '0;
        end
        load_rows();
        repeat (3) @(posedge aclk);
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            send_frame(r);
        end
        in_beat <= '0;
        @(posedge aclk);
        assert_fails = i_port_parser_top.i_port_parser_sva.assert_fail_cnt;
        $display("Frames checked %0d, passed %0d, failed %0d, assertion failures %0d",
            pass_cnt + fail_cnt, pass_cnt, fail_cnt, assert_fails);
        if (fail_cnt == 0 && pass_cnt == NUM_ROWS && assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            if (pass_cnt + fail_cnt != NUM_ROWS) begin
                $display("Only %0d of %0d frames reached the checker",
                    pass_cnt + fail_cnt, NUM_ROWS);
            end
            if (assert_fails != 0) begin
                $display("Bound assertions failed %0d times", assert_fails);
            end
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/dest_port_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module dest_port_filter
    import net_field_pkg::*;
    import stream_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,
    input  logic        frame_end,
    input  port_hit_t   dst_hit,
    input  filter_cfg_t cfg,
    input  port_t       table_ports [NUM_ROUTES],
    output logic        dst_bad,
    output logic        dst_seen,
    output route_mask_t cam_mask
);

    logic        cur_bad;
    logic        bad_q;
    logic        seen_q;
    route_mask_t entry_match;
    route_mask_t match_q;

    // Access check, same rule as on the source side
    assign cur_bad = dst_hit.hit & cfg.match_dest & (dst_hit.port != cfg.dest_port);

    always_ff @(posedge aclk) begin
        if (reset) begin
            bad_q  <= 1'b0;
            seen_q <= 1'b0;
        end else if (frame_end) begin
            bad_q  <= 1'b0;
            seen_q <= 1'b0;
        end else begin
            if (cur_bad) begin
                bad_q <= 1'b1;
            end
            if (dst_hit.hit) begin
                seen_q <= 1'b1;
            end
        end
    end

    assign dst_bad  = cur_bad | bad_q;
    assign dst_seen = dst_hit.hit | seen_q;

    // An entry keeps matching until the port shows up with another value
    always_comb begin
        for (int k = 0; k < NUM_ROUTES; k++) begin
            entry_match[k] = !dst_hit.hit || (dst_hit.port == table_ports[k]);
        end
    end

    // Match bits start each frame set
    always_ff @(posedge aclk) begin
        if (reset) begin
            match_q <= '1;
        end else if (frame_end) begin
            match_q <= '1;
        end else begin
            match_q <= match_q & entry_match;
        end
    end

    assign cam_mask = entry_match & match_q;

endmodule

`default_nettype wire

// ==== rtl/net_field_pkg.sv ====
`default_nettype none

// Byte positions and widths of the transport header fields
// in an Ethernet/IPv4 frame
package net_field_pkg;

    // Source port starts right after a 14 byte MAC and 20 byte IP header
    localparam int SPORT_OFFSET = 34;

    // Destination port follows the source port
    localparam int DPORT_OFFSET = 36;

    // Both ports are 16 bit fields
    localparam int PORT_WIDTH = 16;

    // Largest even shift from IP options
    localparam int MAX_ADDED_OFFSET = 64;

    // Longest tagged frame
    localparam int MAX_PACKET_LENGTH = 1522;

    // Byte positions up to MAX_PACKET_LENGTH
    localparam int POS_WIDTH = 11;

    // Holds 0 up to MAX_ADDED_OFFSET
    localparam int OFFSET_WIDTH = 7;

    // One TCP or UDP port number
    typedef logic [PORT_WIDTH-1:0] port_t;

endpackage

`default_nettype wire

// ==== rtl/port_field_locate.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_field_locate
    import net_field_pkg::*;
    import stream_pkg::*;
(
    input  logic                    aclk,
    input  logic                    reset,
    input  axis_beat_t              beat,
    input  logic                    out_ready,
    input  logic [OFFSET_WIDTH-1:0] added_offset,
    output port_hit_t               src_hit,
    output port_hit_t               dst_hit,
    output logic                    frame_end
);

    logic                                accepted;
    logic [POS_WIDTH-1:0]                beat_cnt;
    logic [POS_WIDTH-1:0]                src_pos;
    logic [POS_WIDTH-1:0]                dst_pos;
    logic [POS_WIDTH-1:0]                src_beat;
    logic [POS_WIDTH-1:0]                dst_beat;
    logic [LANE_SEL_WIDTH-1:0]           src_lane;
    logic [LANE_SEL_WIDTH-1:0]           dst_lane;
    logic [BUS_LANES-1:0][PORT_WIDTH-1:0] lanes;

    assign accepted  = beat.valid & out_ready;
    assign frame_end = accepted & beat.last;

    // Index of the current beat inside the frame
    always_ff @(posedge aclk) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (frame_end) begin
            beat_cnt <= '0;
        end else if (accepted) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Field byte positions after the IP option shift
    assign src_pos = POS_WIDTH'(SPORT_OFFSET) + POS_WIDTH'(added_offset);
    assign dst_pos = POS_WIDTH'(DPORT_OFFSET) + POS_WIDTH'(added_offset);

    // Beat that carries each field, and its 16 bit lane in that beat
    assign src_beat = src_pos / POS_WIDTH'(BUS_BYTES);
    assign dst_beat = dst_pos / POS_WIDTH'(BUS_BYTES);
    assign src_lane = LANE_SEL_WIDTH'((src_pos % POS_WIDTH'(BUS_BYTES)) >> 1);
    assign dst_lane = LANE_SEL_WIDTH'((dst_pos % POS_WIDTH'(BUS_BYTES)) >> 1);

    assign lanes = beat.data;

    assign src_hit.port = lanes[src_lane];
    assign src_hit.hit  = accepted & (src_beat == beat_cnt);

    assign dst_hit.port = lanes[dst_lane];
    assign dst_hit.hit  = accepted & (dst_beat == beat_cnt);

endmodule

`default_nettype wire

// ==== rtl/port_parser_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_parser_top
    import net_field_pkg::*;
    import stream_pkg::*;
(
    input  logic                    aclk,
    input  logic                    reset,
    input  axis_beat_t              in_beat,
    output logic                    in_ready,
    output axis_beat_t              out_beat,
    input  logic                    out_ready,
    input  logic [OFFSET_WIDTH-1:0] added_offset,
    input  filter_cfg_t             cfg,
    input  port_t                   table_ports [NUM_ROUTES],
    input  route_mask_t             must_match,
    input  side_in_t                side_in,
    output side_out_t               side_out
);

    port_hit_t   src_hit;
    port_hit_t   dst_hit;
    logic        frame_end;
    logic        src_bad;
    logic        dst_bad;
    logic        dst_seen;
    route_mask_t cam_mask;

    // Stream passes straight through
    assign out_beat = in_beat;
    assign in_ready = out_ready;

    port_field_locate i_port_field_locate (
        .aclk         (aclk),
        .reset        (reset),
        .beat         (in_beat),
        .out_ready    (out_ready),
        .added_offset (added_offset),
        .src_hit      (src_hit),
        .dst_hit      (dst_hit),
        .frame_end    (frame_end)
    );

    src_port_acl i_src_port_acl (
        .aclk      (aclk),
        .reset     (reset),
        .frame_end (frame_end),
        .src_hit   (src_hit),
        .cfg       (cfg),
        .src_bad   (src_bad)
    );

    dest_port_filter i_dest_port_filter (
        .aclk        (aclk),
        .reset       (reset),
        .frame_end   (frame_end),
        .dst_hit     (dst_hit),
        .cfg         (cfg),
        .table_ports (table_ports),
        .dst_bad     (dst_bad),
        .dst_seen    (dst_seen),
        .cam_mask    (cam_mask)
    );

    verdict_merge i_verdict_merge (
        .src_bad    (src_bad),
        .dst_bad    (dst_bad),
        .dst_seen   (dst_seen),
        .cam_mask   (cam_mask),
        .must_match (must_match),
        .side_in    (side_in),
        .side_out   (side_out)
    );

endmodule

`default_nettype wire

// ==== rtl/src_port_acl.sv ====
`timescale 1ns/1ps
`default_nettype none

module src_port_acl
    import stream_pkg::*;
(
    input  logic        aclk,
    input  logic        reset,
    input  logic        frame_end,
    input  port_hit_t   src_hit,
    input  filter_cfg_t cfg,
    output logic        src_bad
);

    logic cur_bad;
    logic bad_q;

    // Mismatch on the beat that carries the source port
    assign cur_bad = src_hit.hit & cfg.match_src & (src_hit.port != cfg.src_port);

    // Remember the mismatch for the rest of the frame
    always_ff @(posedge aclk) begin
        if (reset) begin
            bad_q <= 1'b0;
        end else if (frame_end) begin
            bad_q <= 1'b0;
        end else if (cur_bad) begin
            bad_q <= 1'b1;
        end
    end

    assign src_bad = cur_bad | bad_q;

endmodule

`default_nettype wire

// ==== rtl/stream_pkg.sv ====
`default_nettype none

// Stream bus shape and the structs that travel between the parser blocks
package stream_pkg;

    import net_field_pkg::*;

    localparam int BUS_WIDTH = 64;
    localparam int BUS_BYTES = BUS_WIDTH / 8;

    // A port always sits in exactly one 16 bit lane
    localparam int BUS_LANES = BUS_WIDTH / 16;
    localparam int LANE_SEL_WIDTH = $clog2(BUS_LANES);

    localparam int NUM_ROUTES = 16;

    typedef logic [NUM_ROUTES-1:0] route_mask_t;

    // One stream beat
    typedef struct packed {
        logic [BUS_WIDTH-1:0] data;
        logic [BUS_BYTES-1:0] keep;
        logic                 last;
        logic                 valid;
    } axis_beat_t;

    // Port value picked off the bus with a strobe on the beat that holds it
    typedef struct packed {
        port_t port;
        logic  hit;
    } port_hit_t;

    typedef struct packed {
        port_t src_port;
        logic  match_src;
        port_t dest_port;
        logic  match_dest;
    } filter_cfg_t;

    // Sideband from the IPv4 stage
    typedef struct packed {
        route_mask_t route_mask;
        logic        poisoned;
        logic        parsing_done;
        logic        has_ports;
    } side_in_t;

    typedef struct packed {
        route_mask_t route_mask;
        logic        poisoned;
        logic        parsing_done;
    } side_out_t;

endpackage

`default_nettype wire

// ==== rtl/verdict_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module verdict_merge
    import stream_pkg::*;
(
    input  logic        src_bad,
    input  logic        dst_bad,
    input  logic        dst_seen,
    input  route_mask_t cam_mask,
    input  route_mask_t must_match,
    input  side_in_t    side_in,
    output side_out_t   side_out
);

    logic        has_ports;
    route_mask_t port_mask;
    route_mask_t allowed;

    assign has_ports = side_in.has_ports;

    // Without a transport header no table entry can match
    assign port_mask = has_ports ? cam_mask : '0;

    // Routes that need no match always stay open
    assign allowed = ~must_match | port_mask;

    assign side_out.route_mask = side_in.route_mask & allowed;

    // Port checks only count for frames that carry ports
    assign side_out.poisoned = side_in.poisoned | (has_ports & (src_bad | dst_bad));

    // Done once the destination port went by
    assign side_out.parsing_done = has_ports ? dst_seen : side_in.parsing_done;

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/net_field_pkg.sv
rtl/stream_pkg.sv
rtl/port_field_locate.sv
rtl/src_port_acl.sv
rtl/dest_port_filter.sv
rtl/verdict_merge.sv
rtl/port_parser_top.sv
bench/port_parser_sva.sv
bench/port_parser_checker.sv
bench/tb_port_parser.sv
